// File: Bender.yml
package:
  name: inst_buffer

sources:
  - design/ibuf_pkg.sv
  - design/bank_fifo.sv
  - design/multi_port_fifo.sv
  - design/inst_buffer.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_inst_buffer.sv

// File: all.f
+incdir+tb
design/ibuf_pkg.sv
design/bank_fifo.sv
design/multi_port_fifo.sv
design/inst_buffer.sv
tb/tb_inst_buffer.sv

// File: design/bank_fifo.sv
`default_nettype none

module bank_fifo
  import ibuf_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  logic     push_i,
  input  logic     pop_i,
  input  payload_t data_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  // ==========================================================================
  // Storage and pointers
  // ==========================================================================

  payload_t                 mem_q [BANK_DEPTH];
  logic [BANK_ADDR_W-1:0]   head_q;
  logic [BANK_ADDR_W-1:0]   tail_q;
  logic [BANK_CNT_W-1:0]    count_q;

  logic                     do_push;
  logic                     do_pop;

  assign full_o  = (count_q == BANK_CNT_W'(BANK_DEPTH));
  assign empty_o = (count_q == '0);

  // Requests against a full or empty bank are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry falls through to the output
  assign data_o = mem_q[head_q];

  always_ff @(posedge clk) begin
    if (do_push && !flush_i) begin
      mem_q[tail_q] <= data_i;
    end
  end

  // ==========================================================================
  // Pointer and occupancy update
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        if (tail_q == BANK_ADDR_W'(BANK_DEPTH - 1)) begin
          tail_q <= '0;
        end else begin
          tail_q <= tail_q + 1'b1;
        end
      end

      if (do_pop) begin
        if (head_q == BANK_ADDR_W'(BANK_DEPTH - 1)) begin
          head_q <= '0;
        end else begin
          head_q <= head_q + 1'b1;
        end
      end

      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================

  // Parent must never steer a write into a full bank
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> !full_o
  ) else $error("bank_fifo: push while full");

  // Parent must only pop a bank whose head it presented as valid
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pop_i && !flush_i) |-> !empty_o
  ) else $error("bank_fifo: pop while empty");

endmodule

`default_nettype wire

// File: design/ibuf_pkg.sv
`default_nettype none

package ibuf_pkg;

  // ==========================================================================
  // Port counts and storage geometry
  // ==========================================================================

  // Fetch slots per cycle
  localparam int unsigned WR_PORTS = 4;
  // Decode slots per cycle
  localparam int unsigned RD_PORTS = 2;

  // One bank per slot of the wider side
  localparam int unsigned NUM_BANKS = (WR_PORTS > RD_PORTS) ? WR_PORTS : RD_PORTS;

  // Entries held by each bank, 16 in total
  localparam int unsigned BANK_DEPTH = 4;

  // ==========================================================================
  // Pointer and counter widths
  // ==========================================================================

  localparam int unsigned BANK_PTR_W  = $clog2(NUM_BANKS);
  localparam int unsigned WR_CNT_W    = $clog2(WR_PORTS + 1);
  localparam int unsigned RD_CNT_W    = $clog2(RD_PORTS + 1);
  localparam int unsigned FULL_CNT_W  = $clog2(NUM_BANKS + 1);

  // Addressing inside a single bank
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_DEPTH);
  localparam int unsigned BANK_CNT_W  = $clog2(BANK_DEPTH + 1);

  // Instruction entry as handed from fetch to decode
  typedef struct packed {
    logic [31:0] instr;
    logic [15:0] pc_lo;
  } ibuf_entry_t;

endpackage

`default_nettype wire

// File: design/inst_buffer.sv
`default_nettype none

module inst_buffer
  import ibuf_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,

  // Fetch stage, up to WR_PORTS entries per cycle
  input  logic        [WR_PORTS-1:0]  wr_valid_i,
  input  ibuf_entry_t [WR_PORTS-1:0]  wr_data_i,
  output logic                        wr_ready_o,

  // Decode stage, up to RD_PORTS entries per cycle
  output logic        [RD_PORTS-1:0]  rd_valid_o,
  input  logic        [RD_PORTS-1:0]  rd_ready_i,
  output ibuf_entry_t [RD_PORTS-1:0]  rd_data_o
);

  // ==========================================================================
  // Banked instruction FIFO
  // ==========================================================================

  // Flush comes from branch redirect and empties the whole buffer
  multi_port_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .wr_valid_i (wr_valid_i),
    .wr_data_i  (wr_data_i),
    .wr_ready_o (wr_ready_o),
    .rd_valid_o (rd_valid_o),
    .rd_ready_i (rd_ready_i),
    .rd_data_o  (rd_data_o)
  );

endmodule

`default_nettype wire

// File: design/multi_port_fifo.sv
`default_nettype none

module multi_port_fifo
  import ibuf_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,

  // Fetch side
  input  logic        [WR_PORTS-1:0]  wr_valid_i,
  input  ibuf_entry_t [WR_PORTS-1:0]  wr_data_i,
  output logic                        wr_ready_o,

  // Decode side
  output logic        [RD_PORTS-1:0]  rd_valid_o,
  input  logic        [RD_PORTS-1:0]  rd_ready_i,
  output ibuf_entry_t [RD_PORTS-1:0]  rd_data_o
);

  // ==========================================================================
  // Declarations
  // ==========================================================================

  // Bank that receives write slot 0 and bank that feeds read slot 0
  logic [BANK_PTR_W-1:0]                wr_ptr_q;
  logic [BANK_PTR_W-1:0]                rd_ptr_q;

  logic [WR_CNT_W-1:0]                  wr_cnt;
  logic [RD_CNT_W-1:0]                  rd_cnt;
  logic [FULL_CNT_W-1:0]                full_cnt;
  logic                                 wr_accept;

  logic        [NUM_BANKS-1:0]          bank_push;
  logic        [NUM_BANKS-1:0]          bank_pop;
  logic        [NUM_BANKS-1:0]          bank_full;
  logic        [NUM_BANKS-1:0]          bank_empty;
  ibuf_entry_t [NUM_BANKS-1:0]          bank_wdata;
  ibuf_entry_t [NUM_BANKS-1:0]          bank_rdata;

  logic [RD_PORTS-1:0][BANK_PTR_W-1:0]  rd_bank;

  // ==========================================================================
  // Slot counts and write acceptance
  // ==========================================================================

  always_comb begin
    wr_cnt = '0;
    for (int k = 0; k < WR_PORTS; k++) begin
      wr_cnt = wr_cnt + WR_CNT_W'(wr_valid_i[k]);
    end

    // Valid and ready are both prefixes, so this counts the moved prefix
    rd_cnt = '0;
    for (int k = 0; k < RD_PORTS; k++) begin
      rd_cnt = rd_cnt + RD_CNT_W'(rd_valid_o[k] & rd_ready_i[k]);
    end

    full_cnt = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      full_cnt = full_cnt + FULL_CNT_W'(bank_full[b]);
    end
  end

  // Room for a whole group is guaranteed only while few banks are full
  assign wr_ready_o = (full_cnt <= FULL_CNT_W'(NUM_BANKS - WR_PORTS));
  assign wr_accept  = (|wr_valid_i) & wr_ready_o & ~flush_i;

  // ==========================================================================
  // Rotating pointers
  // ==========================================================================

  // Arithmetic wraps at NUM_BANKS
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_accept) begin
        wr_ptr_q <= wr_ptr_q + BANK_PTR_W'(wr_cnt);
      end
      rd_ptr_q <= rd_ptr_q + BANK_PTR_W'(rd_cnt);
    end
  end

  // ==========================================================================
  // Banks
  // ==========================================================================

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    // Slot index that maps onto this bank for each direction
    logic [BANK_PTR_W-1:0] wr_off;
    logic [BANK_PTR_W-1:0] rd_off;

    assign wr_off = BANK_PTR_W'(b) - wr_ptr_q;
    assign rd_off = BANK_PTR_W'(b) - rd_ptr_q;

    assign bank_push[b]  = wr_accept & (int'(wr_off) < int'(wr_cnt));
    assign bank_pop[b]   = ~flush_i & (int'(rd_off) < int'(rd_cnt));
    assign bank_wdata[b] = wr_data_i[wr_off];

    bank_fifo #(
      .payload_t (ibuf_entry_t)
    ) u_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush_i (flush_i),
      .push_i  (bank_push[b]),
      .pop_i   (bank_pop[b]),
      .data_i  (bank_wdata[b]),
      .data_o  (bank_rdata[b]),
      .full_o  (bank_full[b]),
      .empty_o (bank_empty[b])
    );
  end

  // ==========================================================================
  // Read slot routing
  // ==========================================================================

  for (genvar k = 0; k < RD_PORTS; k++) begin : gen_rd_slot
    assign rd_bank[k]    = rd_ptr_q + BANK_PTR_W'(k);
    assign rd_valid_o[k] = ~bank_empty[rd_bank[k]];
    assign rd_data_o[k]  = bank_rdata[rd_bank[k]];
  end

  // ==========================================================================
  // Checks
  // ==========================================================================

  // Contiguous from slot 0 means mask plus one is a power of two or zero
  a_wr_valid_contig: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(wr_valid_i + WR_PORTS'(1))
  ) else $error("multi_port_fifo: wr_valid_i not contiguous from slot 0");

  a_rd_ready_contig: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(rd_ready_i + RD_PORTS'(1))
  ) else $error("multi_port_fifo: rd_ready_i not contiguous from slot 0");

  // Round-robin filling keeps bank occupancy ordered from the read pointer
  a_rd_valid_prefix: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(rd_valid_o + RD_PORTS'(1))
  ) else $error("multi_port_fifo: rd_valid_o not a contiguous prefix");

endmodule

`default_nettype wire

// File: tb/ibuf_vectors.svh
`ifndef IBUF_VECTORS_SVH
`define IBUF_VECTORS_SVH

// One row per clock cycle
// Columns are write slots strobed, read slots ready, flush

localparam int NUM_STEPS = 33;

localparam step_t STEPS [NUM_STEPS] = '{
  // Full groups in, pairs out, until no bank has room
  '{3'd4, 2'd0, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd4, 2'd0, 1'b0},
  '{3'd4, 2'd0, 1'b0},
  '{3'd0, 2'd2, 1'b0},
  '{3'd0, 2'd2, 1'b0},
  '{3'd3, 2'd2, 1'b0},
  // Partial groups across pointer wraparound
  '{3'd0, 2'd2, 1'b0},
  '{3'd1, 2'd1, 1'b0},
  '{3'd0, 2'd2, 1'b0},
  '{3'd2, 2'd2, 1'b0},
  '{3'd0, 2'd1, 1'b0},
  '{3'd3, 2'd0, 1'b0},
  '{3'd0, 2'd2, 1'b0},
  '{3'd1, 2'd2, 1'b0},
  // Flush together with writes and reads, then a fresh start
  '{3'd4, 2'd2, 1'b1},
  '{3'd2, 2'd2, 1'b0},
  '{3'd1, 2'd1, 1'b0},
  '{3'd3, 2'd2, 1'b0},
  '{3'd2, 2'd1, 1'b1},
  '{3'd0, 2'd2, 1'b0},
  '{3'd4, 2'd2, 1'b0},
  '{3'd2, 2'd2, 1'b0},
  '{3'd1, 2'd0, 1'b0},
  // Drain
  '{3'd0, 2'd2, 1'b0},
  '{3'd0, 2'd2, 1'b0},
  '{3'd0, 2'd2, 1'b0},
  '{3'd0, 2'd0, 1'b0}
};

`endif

// File: tb/tb_inst_buffer.sv
`default_nettype none

module tb_inst_buffer
  import ibuf_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;

  typedef struct packed {
    logic [2:0] wr;
    logic [1:0] rd;
    logic       flush;
  } step_t;

  `include "ibuf_vectors.svh"

  localparam int WATCHDOG_TIME = (RESET_CYCLES + NUM_STEPS + 20) * CLK_PERIOD;

  logic                        clk;
  logic                        rst_n;
  logic                        flush_i;
  logic        [WR_PORTS-1:0]  wr_valid_i;
  ibuf_entry_t [WR_PORTS-1:0]  wr_data_i;
  logic                        wr_ready_o;
  logic        [RD_PORTS-1:0]  rd_valid_o;
  logic        [RD_PORTS-1:0]  rd_ready_i;
  ibuf_entry_t [RD_PORTS-1:0]  rd_data_o;

  // Reference model, oldest entry at the front
  ibuf_entry_t model_q [$];

  int seed           = 32'hc92d_a607;
  int error_count    = 0;
  int check_count    = 0;
  int refused_groups = 0;

  inst_buffer u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .wr_valid_i (wr_valid_i),
    .wr_data_i  (wr_data_i),
    .wr_ready_o (wr_ready_o),
    .rd_valid_o (rd_valid_o),
    .rd_ready_i (rd_ready_i),
    .rd_data_o  (rd_data_o)
  );

  initial clk = 1'b0;

  always begin
    #(CLK_PERIOD / 2);
    clk = ~clk;
  end

  // ==========================================================================
  // Model helpers
  // ==========================================================================

  // Round-robin fill from the read pointer, so the bank at offset j
  // holds every NUM_BANKS-th entry starting with entry j
  function automatic logic model_ready(input int n);
    int full_banks;
    int fill;
    full_banks = 0;
    for (int j = 0; j < int'(NUM_BANKS); j++) begin
      fill = (n > j) ? (n - j + int'(NUM_BANKS) - 1) / int'(NUM_BANKS) : 0;
      if (fill >= int'(BANK_DEPTH)) begin
        full_banks++;
      end
    end
    return full_banks <= int'(NUM_BANKS - WR_PORTS);
  endfunction

  task automatic check_entry(input string name, input ibuf_entry_t exp, input ibuf_entry_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[FAIL] %s: expected instr=%h pc_lo=%h, actual instr=%h pc_lo=%h",
               name, exp.instr, exp.pc_lo, act.instr, act.pc_lo);
    end
  endtask

  task automatic check_mask(input string name, input logic [RD_PORTS-1:0] exp,
                            input logic [RD_PORTS-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ==========================================================================
  // Stimulus and comparison per step
  // ==========================================================================

  task automatic drive_step(input step_t st);
    ibuf_entry_t entry;
    for (int k = 0; k < int'(WR_PORTS); k++) begin
      entry.instr  = $random(seed);
      entry.pc_lo  = 16'($random(seed));
      wr_data_i[k] = entry;
    end
    wr_valid_i = WR_PORTS'((1 << st.wr) - 1);
    rd_ready_i = RD_PORTS'((1 << st.rd) - 1);
    flush_i    = st.flush;
  endtask

  task automatic check_outputs(input int s);
    int                  n_valid;
    logic [RD_PORTS-1:0] exp_mask;
    n_valid  = (model_q.size() < int'(RD_PORTS)) ? model_q.size() : int'(RD_PORTS);
    exp_mask = RD_PORTS'((1 << n_valid) - 1);
    check_mask($sformatf("step %0d rd_valid_o", s), exp_mask, rd_valid_o);
    check_bit($sformatf("step %0d wr_ready_o", s), model_ready(model_q.size()), wr_ready_o);
    for (int k = 0; k < n_valid; k++) begin
      check_entry($sformatf("step %0d rd_data_o[%0d]", s, k), model_q[k], rd_data_o[k]);
    end
  endtask

  // State after the coming rising edge
  task automatic update_model(input step_t st);
    int   n_valid;
    int   n_moved;
    logic ready;
    n_valid = (model_q.size() < int'(RD_PORTS)) ? model_q.size() : int'(RD_PORTS);
    n_moved = (int'(st.rd) < n_valid) ? int'(st.rd) : n_valid;
    ready   = model_ready(model_q.size());
    if (st.flush) begin
      model_q.delete();
    end else begin
      repeat (n_moved) begin
        void'(model_q.pop_front());
      end
      if (st.wr != 0) begin
        if (ready) begin
          for (int k = 0; k < int'(st.wr); k++) begin
            model_q.push_back(wr_data_i[k]);
          end
        end else begin
          refused_groups++;
        end
      end
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin : stimulus
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    wr_valid_i = '0;
    wr_data_i  = '0;
    rd_ready_i = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_mask("after reset rd_valid_o", '0, rd_valid_o);
    check_bit("after reset wr_ready_o", 1'b1, wr_ready_o);

    for (int s = 0; s < NUM_STEPS; s++) begin
      @(negedge clk);
      drive_step(STEPS[s]);
      #1;
      check_outputs(s);
      update_model(STEPS[s]);
    end

    // Idle cycle to see the final state
    @(negedge clk);
    wr_valid_i = '0;
    rd_ready_i = '0;
    flush_i    = 1'b0;
    #1;
    check_outputs(NUM_STEPS);

    if (refused_groups == 0) begin
      error_count++;
      $display("The stimulus table never drove a write while the buffer was not ready");
    end

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("Watchdog timeout: the stimulus table did not finish within %0d time units",
             WATCHDOG_TIME);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
